// ==== common/pcie_tlp_pkg.sv ====
// PCIe TLP stream package
// Shared widths, beat types and keep encodings for the 64-bit
// core side and the 128-bit TLP stream side of the bridge,
// plus the phase type of the transmit narrower
package pcie_tlp_pkg;

    // --------------------
    // Widths
    // --------------------
    localparam int DW_BITS   = 32;
    localparam int CORE_DW   = 2;
    localparam int TLPS_DW   = 4;
    localparam int BAR_HIT_W = 7;

    // --------------------
    // Beat types
    // --------------------

    // Core side, one 64-bit beat with byte keep
    typedef logic [CORE_DW*DW_BITS-1:0]   core_data_t;
    typedef logic [CORE_DW*DW_BITS/8-1:0] core_keep_t;

    // TLP stream side, one 128-bit beat with dword keep
    typedef logic [TLPS_DW*DW_BITS-1:0]   tlps_data_t;
    typedef logic [TLPS_DW-1:0]           tlps_keepdw_t;

    typedef logic [BAR_HIT_W-1:0]         bar_hit_t;

    // --------------------
    // Keep encodings
    // --------------------

    // Low dword only
    localparam core_keep_t KEEP_ONE_DW = 8'h0f;
    // Both dwords
    localparam core_keep_t KEEP_TWO_DW = 8'hff;

    // Narrower phase, which half of the TLP beat is on the core bus
    typedef enum logic {
        NARROW_LOW,
        NARROW_HIGH
    } narrow_phase_e;

endpackage

// ==== verilog/pcie_reset_ctrl.sv ====
// PCIe reset and LED control
// Combines the system, user, PERST and software reset requests
// into the subsystem and core resets, and blinks the link LED
// from a free-running tick counter while the link is down
`timescale 1ns/1ps

module pcie_reset_ctrl #(
    parameter int LED_BLINK_BIT = 25
) (
    input  logic clk_pcie,
    input  logic rst,
    input  logic pcie_perst_n,
    input  logic link_up,
    input  logic rst_user,
    input  logic rst_subsys_req,
    input  logic rst_core_req,
    output logic rst_subsys,
    output logic rst_core,
    output logic led_state
);

    // Only bits up to the blink bit matter
    logic [LED_BLINK_BIT:0] tick_count;

    // --------------------
    // Reset trees
    // --------------------

    // Subsystem logic behind the core
    assign rst_subsys = rst || rst_user || rst_subsys_req;

    // Hard core, PERST is active low
    assign rst_core = rst || !pcie_perst_n || rst_core_req;

    // --------------------
    // Tick counter and LED
    // --------------------

    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            tick_count <= '0;
        end else begin
            tick_count <= tick_count + 1'b1;
        end
    end

    // Solid when link is up, blinking otherwise
    assign led_state = link_up || tick_count[LED_BLINK_BIT];

endmodule

// ==== tlp_stream/tlp_rx_widen.sv ====
// TLP receive widener
// Packs 64-bit core receive beats into 128-bit TLP beats with a
// per-dword keep, first/last marks and the BAR-hit field. A beat
// is emitted the cycle after the core beat that fills it past two
// dwords or that ends the TLP. There is no back-pressure
`timescale 1ns/1ps

module tlp_rx_widen (
    input  logic                       clk_pcie,
    input  logic                       rst_subsys,
    input  logic                       rx_valid,
    input  logic                       rx_last,
    input  pcie_tlp_pkg::core_data_t   rx_data,
    input  pcie_tlp_pkg::core_keep_t   rx_keep,
    input  pcie_tlp_pkg::bar_hit_t     rx_bar_hit,
    output pcie_tlp_pkg::tlps_data_t   tlps_rx_data,
    output pcie_tlp_pkg::tlps_keepdw_t tlps_rx_keepdw,
    output logic                       tlps_rx_first,
    output logic                       tlps_rx_last,
    output logic                       tlps_rx_valid,
    output pcie_tlp_pkg::bar_hit_t     tlps_rx_bar_hit
);

    // Count holds 0 up to a full TLP beat
    localparam int CNT_W     = $clog2(pcie_tlp_pkg::TLPS_DW + 1);
    localparam int CORE_BITS = pcie_tlp_pkg::DW_BITS * pcie_tlp_pkg::CORE_DW;
    // First byte keep bit of the upper core dword
    localparam int KEEP_HI_BIT = pcie_tlp_pkg::DW_BITS / 8;

    pcie_tlp_pkg::tlps_data_t buf_data;
    pcie_tlp_pkg::bar_hit_t   bar_hit_q;
    logic [CNT_W-1:0]         dw_count;
    logic [CNT_W-1:0]         next_base;
    logic [CNT_W-1:0]         next_count;
    logic                     first_q;
    logic                     last_q;
    logic                     emit;

    // --------------------
    // Emit and offset
    // --------------------

    // Full enough, or end of TLP
    assign emit = last_q || (dw_count > CNT_W'(pcie_tlp_pkg::CORE_DW));

    // A beat taken while emitting starts over at dword 0
    assign next_base  = emit ? '0 : dw_count;
    assign next_count = next_base + (rx_keep[KEEP_HI_BIT] ? CNT_W'(2) : CNT_W'(1));

    // --------------------
    // Control state
    // --------------------

    always_ff @(posedge clk_pcie) begin
        if (rst_subsys) begin
            dw_count <= '0;
            first_q  <= 1'b1;
            last_q   <= 1'b0;
        end else if (rx_valid) begin
            dw_count <= next_count;
            last_q   <= rx_last;
            // Next TLP begins after an emitted last beat
            if (emit) begin
                first_q <= last_q;
            end
        end else if (emit) begin
            dw_count <= '0;
            last_q   <= 1'b0;
            first_q  <= last_q;
        end
    end

    // --------------------
    // Beat buffer
    // --------------------

    always_ff @(posedge clk_pcie) begin
        if (rx_valid) begin
            buf_data[next_base*pcie_tlp_pkg::DW_BITS +: CORE_BITS] <= rx_data;
            bar_hit_q <= rx_bar_hit;
        end
    end

    // Dword n kept when count is above n
    always_comb begin
        for (int n = 0; n < pcie_tlp_pkg::TLPS_DW; n++) begin
            tlps_rx_keepdw[n] = (dw_count > CNT_W'(n));
        end
    end

    assign tlps_rx_data    = buf_data;
    assign tlps_rx_first   = first_q;
    assign tlps_rx_last    = last_q;
    assign tlps_rx_valid   = emit;
    assign tlps_rx_bar_hit = bar_hit_q;

endmodule

// ==== tlp_stream/tlp_tx_narrow.sv ====
// TLP transmit narrower
// Splits each 128-bit TLP beat into one or two 64-bit core beats.
// The low half goes first; the high half follows only when dword 2
// is kept. The input beat is consumed when its final half transfers,
// and everything holds while the core is not ready
`timescale 1ns/1ps

module tlp_tx_narrow (
    input  logic                       clk_pcie,
    input  logic                       rst,
    input  pcie_tlp_pkg::tlps_data_t   tlps_tx_data,
    input  pcie_tlp_pkg::tlps_keepdw_t tlps_tx_keepdw,
    input  logic                       tlps_tx_last,
    input  logic                       tlps_tx_valid,
    input  logic                       tx_ready,
    output logic                       tlps_tx_ready,
    output pcie_tlp_pkg::core_data_t   tx_data,
    output pcie_tlp_pkg::core_keep_t   tx_keep,
    output logic                       tx_last,
    output logic                       tx_valid
);

    localparam int CORE_BITS = pcie_tlp_pkg::DW_BITS * pcie_tlp_pkg::CORE_DW;

    pcie_tlp_pkg::narrow_phase_e phase;
    logic                        xfer;
    logic                        has_high;
    logic                        final_half;

    // --------------------
    // Handshake
    // --------------------

    assign tx_valid = tlps_tx_valid;
    assign xfer     = tx_valid && tx_ready;

    // Dword 2 kept means a second core beat
    assign has_high = tlps_tx_keepdw[2];

    assign final_half    = (phase == pcie_tlp_pkg::NARROW_HIGH) || !has_high;
    assign tlps_tx_ready = xfer && final_half;

    // --------------------
    // Phase register
    // --------------------

    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            phase <= pcie_tlp_pkg::NARROW_LOW;
        end else if (xfer) begin
            if (phase == pcie_tlp_pkg::NARROW_LOW && has_high) begin
                phase <= pcie_tlp_pkg::NARROW_HIGH;
            end else begin
                phase <= pcie_tlp_pkg::NARROW_LOW;
            end
        end
    end

    // --------------------
    // Core beat select
    // --------------------

    always_comb begin
        if (phase == pcie_tlp_pkg::NARROW_HIGH) begin
            // Dwords 2 and 3
            tx_data = tlps_tx_data[CORE_BITS +: CORE_BITS];
            tx_keep = tlps_tx_keepdw[3] ? pcie_tlp_pkg::KEEP_TWO_DW
                                        : pcie_tlp_pkg::KEEP_ONE_DW;
            tx_last = tlps_tx_last;
        end else begin
            // Dwords 0 and 1
            tx_data = tlps_tx_data[0 +: CORE_BITS];
            tx_keep = tlps_tx_keepdw[1] ? pcie_tlp_pkg::KEEP_TWO_DW
                                        : pcie_tlp_pkg::KEEP_ONE_DW;
            // Not last if a high half still follows
            tx_last = tlps_tx_last && !has_high;
        end
    end

endmodule

// ==== verilog/pcie_tlp_bridge.sv ====
// PCIe TLP bridge
// Stream path of a small PCIe endpoint. Widens the 64-bit core
// receive stream to 128-bit TLP beats, narrows 128-bit TLP beats
// back to the 64-bit core transmit stream, and builds the reset
// trees and the link LED
`timescale 1ns/1ps

module pcie_tlp_bridge #(
    parameter int LED_BLINK_BIT = 25
) (
    input  logic                       clk_pcie,
    input  logic                       rst,
    input  logic                       pcie_perst_n,
    input  logic                       link_up,
    input  logic                       rst_user,
    input  logic                       rst_subsys_req,
    input  logic                       rst_core_req,

    // Core receive
    input  pcie_tlp_pkg::core_data_t   rx_data,
    input  pcie_tlp_pkg::core_keep_t   rx_keep,
    input  logic                       rx_last,
    input  logic                       rx_valid,
    input  pcie_tlp_pkg::bar_hit_t     rx_bar_hit,

    // TLP receive stream
    output pcie_tlp_pkg::tlps_data_t   tlps_rx_data,
    output pcie_tlp_pkg::tlps_keepdw_t tlps_rx_keepdw,
    output logic                       tlps_rx_first,
    output logic                       tlps_rx_last,
    output logic                       tlps_rx_valid,
    output pcie_tlp_pkg::bar_hit_t     tlps_rx_bar_hit,

    // TLP transmit stream
    input  pcie_tlp_pkg::tlps_data_t   tlps_tx_data,
    input  pcie_tlp_pkg::tlps_keepdw_t tlps_tx_keepdw,
    input  logic                       tlps_tx_last,
    input  logic                       tlps_tx_valid,
    output logic                       tlps_tx_ready,

    // Core transmit
    output pcie_tlp_pkg::core_data_t   tx_data,
    output pcie_tlp_pkg::core_keep_t   tx_keep,
    output logic                       tx_last,
    output logic                       tx_valid,
    input  logic                       tx_ready,

    // Resets and LED
    output logic                       rst_subsys,
    output logic                       rst_core,
    output logic                       led_state
);

    // --------------------
    // Reset and LED
    // --------------------

    pcie_reset_ctrl #(
        .LED_BLINK_BIT  (LED_BLINK_BIT)
    ) u_reset_ctrl (
        .clk_pcie       (clk_pcie),
        .rst            (rst),
        .pcie_perst_n   (pcie_perst_n),
        .link_up        (link_up),
        .rst_user       (rst_user),
        .rst_subsys_req (rst_subsys_req),
        .rst_core_req   (rst_core_req),
        .rst_subsys     (rst_subsys),
        .rst_core       (rst_core),
        .led_state      (led_state)
    );

    // --------------------
    // Receive path
    // --------------------

    // Subsystem reset, also cleared by core user reset
    tlp_rx_widen u_rx_widen (
        .clk_pcie        (clk_pcie),
        .rst_subsys      (rst_subsys),
        .rx_valid        (rx_valid),
        .rx_last         (rx_last),
        .rx_data         (rx_data),
        .rx_keep         (rx_keep),
        .rx_bar_hit      (rx_bar_hit),
        .tlps_rx_data    (tlps_rx_data),
        .tlps_rx_keepdw  (tlps_rx_keepdw),
        .tlps_rx_first   (tlps_rx_first),
        .tlps_rx_last    (tlps_rx_last),
        .tlps_rx_valid   (tlps_rx_valid),
        .tlps_rx_bar_hit (tlps_rx_bar_hit)
    );

    // --------------------
    // Transmit path
    // --------------------

    // Runs on the system reset only
    tlp_tx_narrow u_tx_narrow (
        .clk_pcie       (clk_pcie),
        .rst            (rst),
        .tlps_tx_data   (tlps_tx_data),
        .tlps_tx_keepdw (tlps_tx_keepdw),
        .tlps_tx_last   (tlps_tx_last),
        .tlps_tx_valid  (tlps_tx_valid),
        .tx_ready       (tx_ready),
        .tlps_tx_ready  (tlps_tx_ready),
        .tx_data        (tx_data),
        .tx_keep        (tx_keep),
        .tx_last        (tx_last),
        .tx_valid       (tx_valid)
    );

endmodule

// ==== test/pcie_tlp_bridge_asserts.sv ====
// TLP stream converter assertions
// Transmit beat hold under back-pressure, input ready only on a
// core transfer that carries the beat's last mark, and dword 0
// kept on every receive beat
`timescale 1ns/1ps

module pcie_tlp_bridge_asserts (
    input logic                       clk_pcie,
    input logic                       rst,
    input logic                       tx_valid,
    input logic                       tx_ready,
    input pcie_tlp_pkg::core_data_t   tx_data,
    input pcie_tlp_pkg::core_keep_t   tx_keep,
    input logic                       tx_last,
    input logic                       tlps_tx_last,
    input logic                       tlps_tx_ready,
    input logic                       tlps_rx_valid,
    input pcie_tlp_pkg::tlps_keepdw_t tlps_rx_keepdw
);

    // Count of failed assertions
    int fail_count = 0;

    // Core beat held while the core stalls
    tx_hold_a: assert property (@(posedge clk_pcie) disable iff (rst)
        tx_valid && !tx_ready |=> $stable(tx_data) && $stable(tx_keep) && $stable(tx_last))
        else begin
            fail_count++;
            $error("tx beat changed while tx_ready was low");
        end

    // Input beat consumed only by the transfer of its final half
    tx_ready_a: assert property (@(posedge clk_pcie) disable iff (rst)
        tlps_tx_ready |-> tx_valid && tx_ready && (tx_last == tlps_tx_last))
        else begin
            fail_count++;
            $error("tlps_tx_ready without a final core transfer");
        end

    rx_keep_a: assert property (@(posedge clk_pcie) disable iff (rst)
        tlps_rx_valid |-> tlps_rx_keepdw[0])
        else begin
            fail_count++;
            $error("receive beat without dword 0 kept");
        end

endmodule

// Transmit side, receive ports tied idle
bind tlp_tx_narrow pcie_tlp_bridge_asserts u_tx_asserts (
    .*,
    .tlps_rx_valid  (1'b0),
    .tlps_rx_keepdw (4'b0001)
);

// Receive side, transmit ports tied idle
bind tlp_rx_widen pcie_tlp_bridge_asserts u_rx_asserts (
    .*,
    .rst           (rst_subsys),
    .tx_valid      (1'b0),
    .tx_ready      (1'b1),
    .tx_data       (64'h0),
    .tx_keep       (8'h0),
    .tx_last       (1'b0),
    .tlps_tx_last  (1'b0),
    .tlps_tx_ready (1'b0)
);

// ==== test/tb_pcie_tlp_bridge.sv ====
// Testbench for the PCIe TLP bridge
// Random core receive beats and TLP transmit beats from a fixed
// seed, checked against models of the widening and narrowing rules,
// plus the reset fan-out and the LED blink
`timescale 1ns/1ps

module tb_pcie_tlp_bridge;

    localparam int CLK_PERIOD  = 100;
    localparam int N_RST_COMBO = 16;
    localparam int N_RX_TLP    = 40;
    localparam int N_TX_BEAT   = 60;
    localparam int N_LED       = 24;
    // Worst case per test, gaps and back-pressure included
    localparam int TEST_CYCLES = 4 + N_RST_COMBO + N_RX_TLP * 36 + 2 * N_TX_BEAT * 12
                               + 2 * N_LED;

    logic clk_pcie, rst, pcie_perst_n, link_up, rst_user, rst_subsys_req, rst_core_req;
    logic rx_last, rx_valid, tlps_rx_first, tlps_rx_last, tlps_rx_valid;
    logic tlps_tx_last, tlps_tx_valid, tlps_tx_ready, tx_last, tx_valid, tx_ready;
    logic rst_subsys, rst_core, led_state;
    pcie_tlp_pkg::core_data_t   rx_data, tx_data;
    pcie_tlp_pkg::core_keep_t   rx_keep, tx_keep;
    pcie_tlp_pkg::bar_hit_t     rx_bar_hit, tlps_rx_bar_hit;
    pcie_tlp_pkg::tlps_data_t   tlps_rx_data, tlps_tx_data;
    pcie_tlp_pkg::tlps_keepdw_t tlps_rx_keepdw, tlps_tx_keepdw;

    logic [31:0] lcg_state = 32'hce2;
    int          cyc       = 0;
    int          led_ticks = 0;
    int          err_count = 0;
    logic        checking  = 1'b0;

    // Expected receive beats and the cycle each one is due
    pcie_tlp_pkg::tlps_data_t   rx_exp_data[$];
    pcie_tlp_pkg::tlps_keepdw_t rx_exp_keep[$];
    logic                       rx_exp_first[$];
    logic                       rx_exp_last[$];
    pcie_tlp_pkg::bar_hit_t     rx_exp_bar[$];
    int                         rx_exp_due[$];

    pcie_tlp_bridge #(.LED_BLINK_BIT(3)) u_dut (.*);

    // --------------------
    // Random numbers and checks
    // --------------------

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Upper bits only, the low ones cycle quickly
    function automatic int rand_below(int n);
        logic [31:0] r;
        r = lcg_next();
        return int'(r[31:16]) % n;
    endfunction

    function automatic logic rand_bit();
        return rand_below(2) == 1;
    endfunction

    task automatic stop_on_error(string msg);
        $display("ERROR at %0t: %s", $time, msg);
        $display("Errors found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("%s is %b, expected %b", name, got, exp));
        end
    endtask

    task automatic check_tlps_beat(pcie_tlp_pkg::tlps_data_t exp_data,
                                   pcie_tlp_pkg::tlps_keepdw_t exp_keep,
                                   logic exp_first, logic exp_last,
                                   pcie_tlp_pkg::bar_hit_t exp_bar);
        pcie_tlp_pkg::tlps_data_t mask;
        int n;
        mask = '0;
        // Unkept dwords are ignored
        for (n = 0; n < pcie_tlp_pkg::TLPS_DW; n++) begin
            if (exp_keep[n]) begin
                mask = mask | (pcie_tlp_pkg::tlps_data_t'(32'hffff_ffff) << (n * 32));
            end
        end
        if ((tlps_rx_data & mask) !== (exp_data & mask) || tlps_rx_keepdw !== exp_keep
            || tlps_rx_first !== exp_first || tlps_rx_last !== exp_last
            || tlps_rx_bar_hit !== exp_bar) begin
            stop_on_error($sformatf("rx beat %h k%b f%b l%b bar %h, expected %h k%b f%b l%b bar %h",
                tlps_rx_data, tlps_rx_keepdw, tlps_rx_first, tlps_rx_last, tlps_rx_bar_hit,
                exp_data, exp_keep, exp_first, exp_last, exp_bar));
        end
    endtask

    task automatic check_core_beat(pcie_tlp_pkg::core_data_t exp_data,
                                   pcie_tlp_pkg::core_keep_t exp_keep, logic exp_last);
        if (tx_data !== exp_data || tx_keep !== exp_keep || tx_last !== exp_last) begin
            stop_on_error($sformatf("tx beat %h keep %h last %b, expected %h keep %h last %b",
                tx_data, tx_keep, tx_last, exp_data, exp_keep, exp_last));
        end
    endtask

    // --------------------
    // Clock, counters, monitor
    // --------------------

    initial begin
        clk_pcie = 1'b0;
        forever #(CLK_PERIOD / 2) clk_pcie = ~clk_pcie;
    end

    // Cycle stamp and the LED tick model
    always @(posedge clk_pcie) begin
        cyc <= cyc + 1;
        led_ticks <= rst ? 0 : led_ticks + 1;
    end

    always @(negedge clk_pcie) begin
        if (checking) begin
            if (rx_exp_due.size() > 0 && rx_exp_due[0] == cyc) begin
                check_bit("tlps_rx_valid", tlps_rx_valid, 1'b1);
                check_tlps_beat(rx_exp_data.pop_front(), rx_exp_keep.pop_front(),
                                rx_exp_first.pop_front(), rx_exp_last.pop_front(),
                                rx_exp_bar.pop_front());
                rx_exp_due.delete(0);
            end else begin
                check_bit("tlps_rx_valid", tlps_rx_valid, 1'b0);
            end
            check_bit("led_state", led_state, link_up || led_ticks[3]);
        end
    end

    initial begin
        #(TEST_CYCLES * 4 * CLK_PERIOD);
        $display("Watchdog timeout, the tests did not finish in time");
        $display("Errors found");
        $fatal(1, "Watchdog expired");
    end

    // --------------------
    // Tests
    // --------------------

    task automatic run_reset_tests();
        int i;
        for (i = 0; i < N_RST_COMBO; i++) begin
            @(posedge clk_pcie);
            #1;
            rst_user       = rand_bit();
            rst_subsys_req = rand_bit();
            rst_core_req   = rand_bit();
            pcie_perst_n   = rand_bit();
            @(negedge clk_pcie);
            check_bit("rst_subsys", rst_subsys, rst_user || rst_subsys_req);
            check_bit("rst_core", rst_core, !pcie_perst_n || rst_core_req);
            check_bit("tx_valid", tx_valid, 1'b0);
            check_bit("tlps_tx_ready", tlps_tx_ready, 1'b0);
        end
        @(posedge clk_pcie);
        #1;
        {rst_user, rst_subsys_req, rst_core_req, pcie_perst_n} = 4'b0001;
    endtask

    task automatic run_rx_tests();
        pcie_tlp_pkg::tlps_data_t acc;
        pcie_tlp_pkg::bar_hit_t   bar;
        logic [31:0] dw0, dw1;
        logic        first, last;
        int          t, n_dw, pos, size, cnt;
        for (t = 0; t < N_RX_TLP; t++) begin
            n_dw  = 1 + rand_below(12);
            pos   = 0;
            cnt   = 0;
            acc   = '0;
            first = 1'b1;
            while (pos < n_dw) begin
                size = (n_dw - pos >= 2 && rand_bit()) ? 2 : 1;
                dw0  = lcg_next();
                dw1  = lcg_next();
                bar  = pcie_tlp_pkg::bar_hit_t'(lcg_next());
                pos += size;
                last = (pos == n_dw);
                @(posedge clk_pcie);
                #1;
                rx_valid   = 1'b1;
                rx_data    = {dw1, dw0};
                rx_keep    = (size == 2) ? pcie_tlp_pkg::KEEP_TWO_DW : pcie_tlp_pkg::KEEP_ONE_DW;
                rx_last    = last;
                rx_bar_hit = bar;
                // Pack dwords at the running offset
                acc = acc | (pcie_tlp_pkg::tlps_data_t'(dw0) << (cnt * 32));
                if (size == 2) begin
                    acc = acc | (pcie_tlp_pkg::tlps_data_t'(dw1) << ((cnt + 1) * 32));
                end
                cnt += size;
                if (cnt > 2 || last) begin
                    rx_exp_data.push_back(acc);
                    rx_exp_keep.push_back(pcie_tlp_pkg::tlps_keepdw_t'((1 << cnt) - 1));
                    rx_exp_first.push_back(first);
                    rx_exp_last.push_back(last);
                    rx_exp_bar.push_back(bar);
                    rx_exp_due.push_back(cyc + 1);
                    first = 1'b0;
                    cnt   = 0;
                    acc   = '0;
                end
                repeat (rand_below(3)) begin
                    @(posedge clk_pcie);
                    #1;
                    rx_valid = 1'b0;
                end
            end
        end
        @(posedge clk_pcie);
        #1;
        rx_valid = 1'b0;
        repeat (3) @(posedge clk_pcie);
        if (rx_exp_due.size() != 0) begin
            stop_on_error("receive beats expected from the model were never emitted");
        end
    endtask

    task automatic run_tx_tests(int n_beats, logic random_ready);
        pcie_tlp_pkg::tlps_data_t   data;
        pcie_tlp_pkg::tlps_keepdw_t keepdw;
        logic last, xfer;
        int   b, n_halves, half;
        for (b = 0; b < n_beats; b++) begin
            keepdw   = pcie_tlp_pkg::tlps_keepdw_t'((1 << (1 + rand_below(4))) - 1);
            data     = {lcg_next(), lcg_next(), lcg_next(), lcg_next()};
            last     = rand_bit();
            n_halves = keepdw[2] ? 2 : 1;
            repeat (rand_below(3)) begin
                @(posedge clk_pcie);
                #1;
                tlps_tx_valid = 1'b0;
                tx_ready      = random_ready ? rand_bit() : 1'b1;
                @(negedge clk_pcie);
                check_bit("tx_valid", tx_valid, 1'b0);
                check_bit("tlps_tx_ready", tlps_tx_ready, 1'b0);
            end
            @(posedge clk_pcie);
            #1;
            {tlps_tx_valid, tlps_tx_data, tlps_tx_keepdw, tlps_tx_last} = {1'b1, data, keepdw, last};
            tx_ready = random_ready ? rand_bit() : 1'b1;
            half = 0;
            while (half < n_halves) begin
                @(negedge clk_pcie);
                check_bit("tx_valid", tx_valid, 1'b1);
                // Low half first, high half only when dword 2 is kept
                if (half == 0) begin
                    check_core_beat(data[63:0], keepdw[1] ? pcie_tlp_pkg::KEEP_TWO_DW
                                    : pcie_tlp_pkg::KEEP_ONE_DW, last && !keepdw[2]);
                end else begin
                    check_core_beat(data[127:64], keepdw[3] ? pcie_tlp_pkg::KEEP_TWO_DW
                                    : pcie_tlp_pkg::KEEP_ONE_DW, last);
                end
                xfer = tx_ready;
                check_bit("tlps_tx_ready", tlps_tx_ready, xfer && half == n_halves - 1);
                if (xfer) begin
                    half++;
                end
                if (half < n_halves) begin
                    @(posedge clk_pcie);
                    #1;
                    tx_ready = random_ready ? rand_bit() : 1'b1;
                end
            end
        end
        @(posedge clk_pcie);
        #1;
        tlps_tx_valid = 1'b0;
        tx_ready      = 1'b0;
    endtask

    initial begin
        {rst, pcie_perst_n, link_up, rst_user, rst_subsys_req, rst_core_req} = 6'b110000;
        {rx_valid, rx_last, rx_data, rx_keep, rx_bar_hit} = '0;
        {tlps_tx_valid, tlps_tx_last, tlps_tx_data, tlps_tx_keepdw, tx_ready} = '0;
        repeat (4) @(posedge clk_pcie);
        #1;
        rst      = 1'b0;
        checking = 1'b1;
        run_reset_tests();
        run_rx_tests();
        run_tx_tests(N_TX_BEAT, 1'b0);
        run_tx_tests(N_TX_BEAT, 1'b1);
        // LED solid with link up, blinking again after it drops
        link_up = 1'b1;
        repeat (N_LED) @(posedge clk_pcie);
        #1;
        link_up = 1'b0;
        repeat (N_LED) @(posedge clk_pcie);
        // Failed bound assertions
        err_count = u_dut.u_tx_narrow.u_tx_asserts.fail_count
                  + u_dut.u_rx_widen.u_rx_asserts.fail_count;
        if (err_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== pcie_tlp_bridge.f ====
common/pcie_tlp_pkg.sv
verilog/pcie_reset_ctrl.sv
tlp_stream/tlp_rx_widen.sv
tlp_stream/tlp_tx_narrow.sv
verilog/pcie_tlp_bridge.sv
test/pcie_tlp_bridge_asserts.sv
test/tb_pcie_tlp_bridge.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_pcie_tlp_bridge -f pcie_tlp_bridge.f

./obj_dir/Vtb_pcie_tlp_bridge | tee sim.log

if grep -q "No errors" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
